/* flist.f */
+incdir+hdl
hdl/his_pkg.sv
hdl/his_sequencer.sv
hdl/his_bin_ram.sv
hdl/his_wb_readout.sv
hdl/his_top.sv
dv/his_sva.sv
dv/his_tb.sv

/* dv/his_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "his_macros.svh"

module his_tb;

    import his_pkg::*;

    localparam int N_FRAMES = 3;
    localparam int N_READS  = 214;
    // 40 ns per cycle, doubled for margin
    localparam int LIMIT_NS = (N_FRAMES * 96 + N_READS * 3) * 40 * 2;
    // register view: space bit, unused bits, index
    localparam logic [`HIS_ADR_W-1:0] ADR_STATUS  = {1'b1, 5'b0, 1'b0};
    localparam logic [`HIS_ADR_W-1:0] ADR_RELEASE = {1'b1, 5'b0, 1'b1};

    logic        clk = 1'b0;
    logic        res;
    his_hit_t    hit;
    his_wb_req_t wb_req;
    his_wb_rsp_t wb_rsp;
    logic        bank_ready;

    logic [31:0] rng;
    int          checks, errors, test_errors;

    // both model banks, index {bank, pix, bin}
    logic [`HIS_CNT_W-1:0] model_mem [0:127] = '{default: '0};
    // counter nesting as in the sequencer
    int                    m_hit, m_pix, m_acq;
    logic                  m_fill, m_ready, m_overrun;
    logic [7:0]            m_frames;
    logic [`HIS_NB_W-1:0]  last_bin;

    his_top i_his_top (
        .clk        (clk),
        .res        (res),
        .hit        (hit),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .bank_ready (bank_ready)
    );

    always #20 clk = ~clk;

    // watchdog
    initial begin
        #(LIMIT_NS);
        $display("timeout: run did not finish within %0d ns", LIMIT_NS);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [15:0] status_exp();
        logic [15:0] w;
        w = '0;
        w[`HIS_ST_READY]   = m_ready;
        w[`HIS_ST_OVERRUN] = m_overrun;
        w[`HIS_ST_BANK]    = m_fill;
        w[`HIS_ST_FRAME_LSB +: 8] = m_frames;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            test_errors++;
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic model_hit(input logic [`HIS_NB_W-1:0] bin);
        int idx;
        idx = {m_fill, m_pix[`HIS_PIX_W-1:0], bin};
        // counters saturate
        if (model_mem[idx] != '1) begin
            model_mem[idx] = model_mem[idx] + 1'b1;
        end
        m_hit = (m_hit + 1) % `HIS_DATA_NUM;
        if (m_hit == 0) begin
            m_pix = (m_pix + 1) % (1 << `HIS_PIX_W);
        end
        if (m_hit == 0 && m_pix == 0) begin
            m_acq = (m_acq + 1) % `HIS_ACQ_NUM;
        end
        // end of frame, banks swap
        if (m_hit == 0 && m_pix == 0 && m_acq == 0) begin
            m_overrun = m_overrun | m_ready;
            m_ready   = 1'b1;
            m_fill    = ~m_fill;
            m_frames++;
        end
    endtask

    task automatic send_hits(input int n, input int gap_max, input bit repeat_bias);
        logic [`HIS_NB_W-1:0] bin;
        for (int i = 0; i < n; i++) begin
            rng = xorshift32(rng);
            bin = rng[11:8];
            // mostly the previous bin, keeps the increment forwarding busy
            if (repeat_bias && rng[13:12] != 2'b00) begin
                bin = last_bin;
            end
            repeat (rng[3:0] % (gap_max + 1)) begin
                @(posedge clk);
                hit <= '0;
            end
            @(posedge clk);
            hit <= '{valid: 1'b1, bin: bin};
            last_bin = bin;
            model_hit(bin);
        end
        @(posedge clk);
        hit <= '0;
    endtask

    task automatic wb_cycle(input logic we, input his_adr_u adr, output logic [15:0] rdat);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: 16'h0001};
        // request held until ack
        do begin
            @(negedge clk);
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic read_bin(input int pix, input int bin);
        his_adr_u    adr;
        logic [15:0] d;
        int          idx;
        adr.hist.space = 1'b0;
        adr.hist.pix   = pix;
        adr.hist.bin   = bin;
        // finished bank is the one not filled
        idx = {~m_fill, adr.hist.pix, adr.hist.bin};
        wb_cycle(1'b0, adr, d);
        check_value($sformatf("wb_rsp.dat (bank %0d, pixel %0d, bin %0d)", !m_fill, pix, bin),
                    d, model_mem[idx]);
        model_mem[idx] = '0;
    endtask

    task automatic read_bank();
        for (int p = 0; p < (1 << `HIS_PIX_W); p++) begin
            for (int b = 0; b < (1 << `HIS_NB_W); b++) begin
                read_bin(p, b);
            end
        end
    endtask

    task automatic check_status();
        logic [15:0] d;
        @(negedge clk);
        check_value("bank_ready", bank_ready, m_ready);
        wb_cycle(1'b0, ADR_STATUS, d);
        check_value("status", d, status_exp());
    endtask

    task automatic release_bank();
        logic [15:0] d;
        wb_cycle(1'b1, ADR_RELEASE, d);
        m_ready   = 1'b0;
        m_overrun = 1'b0;
    endtask

    task automatic wait_frame();
        do begin
            @(negedge clk);
        end while (!bank_ready);
        // status settles 2 cycles after the last hit
        repeat (4) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        $display("%s: %s, %0d errors", name, test_errors == 0 ? "ok" : "FAIL", test_errors);
        test_errors = 0;
    endtask

    initial begin
        res         = 1'b0;
        hit         = '0;
        wb_req      = '0;
        rng         = 32'd10;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        m_hit       = 0;
        m_pix       = 0;
        m_acq       = 0;
        m_fill      = 1'b0;
        m_ready     = 1'b0;
        m_overrun   = 1'b0;
        m_frames    = '0;
        last_bin    = '0;
        repeat (8) @(posedge clk);
        res <= 1'b1;

        check_status();
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            read_bin(rng[5:4], rng[3:0]);
        end
        end_test("test 1 reset state");

        send_hits(96, 2, 1'b0);
        wait_frame();
        check_status();
        end_test("test 2 first frame");

        read_bank();
        // cleared on the first read
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            read_bin(rng[5:4], rng[3:0]);
        end
        end_test("test 3 readout");

        release_bank();
        send_hits(96, 0, 1'b1);
        wait_frame();
        // next frame fills the other bank during the readout
        fork
            send_hits(60, 1, 1'b0);
            read_bank();
        join
        end_test("test 4 forwarding");

        // completes frame 3 with frame 2 unreleased
        send_hits(36, 1, 1'b0);
        wait_frame();
        check_status();
        read_bank();
        release_bank();
        check_status();
        end_test("test 5 overrun");

        $display("%0d checks, %0d check errors, %0d assertion failures",
                 checks, errors, i_his_top.i_his_sva.fail_cnt);
        if (errors == 0 && i_his_top.i_his_sva.fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/his_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module his_sva (
    input logic                 clk,
    input logic                 res,
    input his_pkg::his_wb_req_t wb_req,
    input his_pkg::his_wb_rsp_t wb_rsp,
    input his_pkg::his_incr_t   incr,
    input logic                 frame_done,
    input logic                 fill_bank
);

    // failed assertions so far
    int fail_cnt = 0;

    // ack only answers an active cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (!res)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
    else begin
        fail_cnt++;
        $error("ack outside an active bus cycle");
    end

    // ack lasts one cycle
    ack_single: assert property (@(posedge clk) disable iff (!res)
        wb_rsp.ack |=> !wb_rsp.ack)
    else begin
        fail_cnt++;
        $error("ack high for two cycles in a row");
    end

    ack_reset: assert property (@(posedge clk) !res |-> !wb_rsp.ack)
    else begin
        fail_cnt++;
        $error("ack high during reset");
    end

    // increment targets the fill bank, except the last hit of a frame
    // which still lands in the old bank while fill_bank has moved on
    incr_bank_match: assert property (@(posedge clk) disable iff (!res)
        incr.valid |-> incr.bank == (fill_bank ^ frame_done))
    else begin
        fail_cnt++;
        $error("increment bank differs from the fill bank");
    end

endmodule

bind his_top his_sva i_his_sva (
    .clk        (clk),
    .res        (res),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .incr       (incr),
    .frame_done (frame_done),
    .fill_bank  (fill_bank)
);

`default_nettype wire

/* hdl/his_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "his_macros.svh"

module his_top (
    input  logic                 clk,
    input  logic                 res,
    input  his_pkg::his_hit_t    hit,
    input  his_pkg::his_wb_req_t wb_req,
    output his_pkg::his_wb_rsp_t wb_rsp,
    output logic                 bank_ready
);

    import his_pkg::*;

    // sequencer to memory
    his_incr_t incr;
    logic      frame_done;
    logic      fill_bank;

    // readout to memory
    his_rd_req_t           rd_req;
    logic [`HIS_CNT_W-1:0] rd_data;

    // tags hits with pixel and bank
    his_sequencer i_his_sequencer (
        .clk        (clk),
        .res        (res),
        .hit        (hit),
        .incr       (incr),
        .frame_done (frame_done),
        .fill_bank  (fill_bank)
    );

    // two banks of bin counters
    his_bin_ram i_his_bin_ram (
        .clk     (clk),
        .res     (res),
        .incr    (incr),
        .rd_req  (rd_req),
        .rd_data (rd_data)
    );

    // host side
    his_wb_readout i_his_wb_readout (
        .clk        (clk),
        .res        (res),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .frame_done (frame_done),
        .fill_bank  (fill_bank),
        .rd_req     (rd_req),
        .rd_data    (rd_data),
        .bank_ready (bank_ready)
    );

endmodule

`default_nettype wire

/* hdl/his_wb_readout.sv */
`timescale 1ns/10ps
`default_nettype none

`include "his_macros.svh"

module his_wb_readout (
    input  logic                  clk,
    input  logic                  res,
    input  his_pkg::his_wb_req_t  wb_req,
    output his_pkg::his_wb_rsp_t  wb_rsp,
    input  logic                  frame_done,
    input  logic                  fill_bank,
    output his_pkg::his_rd_req_t  rd_req,
    input  logic [`HIS_CNT_W-1:0] rd_data,
    output logic                  bank_ready
);

    import his_pkg::*;

    his_adr_u adr;

    // new cycle seen, not yet acknowledged
    logic req_new;
    logic hist_sel;
    logic release_cmd;

    logic ack_q;
    // data source for the current ack
    logic                  hist_q;
    logic [`HIS_CNT_W-1:0] stat_q;

    // status registers
    logic                      ready;
    logic                      overrun;
    logic [`HIS_ST_FRAME_W-1:0] frame_cnt;
    logic [`HIS_CNT_W-1:0]     status;

    assign adr = wb_req.adr;

    assign req_new  = wb_req.cyc && wb_req.stb && !ack_q;
    assign hist_sel = !adr.hist.space;

    assign release_cmd = req_new && wb_req.we && adr.regs.space
                         && (adr.regs.idx == `HIS_REG_RELEASE);

    // single read pulse into the memory, data comes back with ack
    assign rd_req = '{
        en:  req_new && !wb_req.we && hist_sel,
        pix: adr.hist.pix,
        bin: adr.hist.bin
    };

    // status word assembly
    always_comb begin
        status = '0;
        status[`HIS_ST_READY]   = ready;
        status[`HIS_ST_OVERRUN] = overrun;
        status[`HIS_ST_BANK]    = fill_bank;
        status[`HIS_ST_FRAME_LSB +: `HIS_ST_FRAME_W] = frame_cnt;
    end

    // ack one cycle after sampling
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new;
        end
    end

    // capture what the ack will return
    always_ff @(posedge clk) begin
        if (req_new) begin
            hist_q <= hist_sel;
            stat_q <= status;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ready     <= 1'b0;
            overrun   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            if (release_cmd) begin
                ready   <= 1'b0;
                overrun <= 1'b0;
            end
            // new frame wins over a release in the same cycle
            if (frame_done) begin
                ready     <= 1'b1;
                frame_cnt <= frame_cnt + 1'b1;
                // previous bank never released
                if (ready && !release_cmd) begin
                    overrun <= 1'b1;
                end
            end
        end
    end

    assign wb_rsp = '{
        ack: ack_q,
        dat: hist_q ? rd_data : stat_q
    };

    assign bank_ready = ready;

endmodule

`default_nettype wire

/* hdl/his_bin_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "his_macros.svh"

module his_bin_ram (
    input  logic                  clk,
    input  logic                  res,
    input  his_pkg::his_incr_t    incr,
    input  his_pkg::his_rd_req_t  rd_req,
    output logic [`HIS_CNT_W-1:0] rd_data
);

    import his_pkg::*;

    // both banks in one array, address is {bank, pix, bin}
    logic [`HIS_CNT_W-1:0] mem [0:(2**(`HIS_PIX_W+`HIS_NB_W+1))-1];

    // stage one, request plus counter value read from memory
    his_incr_t             s1;
    logic [`HIS_CNT_W-1:0] s1_cnt;
    // stage two result, written back on the next edge
    logic [`HIS_CNT_W-1:0] s1_sum;

    logic [`HIS_PIX_W+`HIS_NB_W:0] incr_addr;
    logic [`HIS_PIX_W+`HIS_NB_W:0] s1_addr;
    logic [`HIS_PIX_W+`HIS_NB_W:0] rd_addr;

    // back-to-back hit on the same bin
    logic fwd;

    assign incr_addr = {incr.bank, incr.pix, incr.bin};
    assign s1_addr   = {s1.bank, s1.pix, s1.bin};
    // readout always sees the bank not being filled
    assign rd_addr   = {~s1.bank, rd_req.pix, rd_req.bin};

    assign fwd = s1.valid && incr.valid && (s1_addr == incr_addr);

    // saturate at all ones
    assign s1_sum = (s1_cnt == '1) ? s1_cnt : s1_cnt + 1'b1;

    // stage one control, bank tracked every cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1 <= '0;
        end else begin
            s1 <= incr;
        end
    end

    // stage one counter read
    always_ff @(posedge clk) begin
        if (incr.valid) begin
            // stale memory word when the previous hit hit the same bin
            if (fwd) begin
                s1_cnt <= s1_sum;
            end else begin
                s1_cnt <= mem[incr_addr];
            end
        end
    end

    // stage two write back and clear-on-read
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // sweep both banks
            for (int i = 0; i < $size(mem); i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (rd_req.en) begin
                mem[rd_addr] <= '0;
            end
            // read and increment target different banks
            if (s1.valid) begin
                mem[s1_addr] <= s1_sum;
            end
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_req.en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/his_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "his_macros.svh"

module his_sequencer (
    input  logic               clk,
    input  logic               res,
    input  his_pkg::his_hit_t  hit,
    output his_pkg::his_incr_t incr,
    output logic               frame_done,
    output logic               fill_bank
);

    // nested position counters
    logic [$clog2(`HIS_DATA_NUM)-1:0] hit_cnt;
    logic [`HIS_PIX_W-1:0]            pix_cnt;
    logic [$clog2(`HIS_ACQ_NUM)-1:0]  acq_cnt;

    // wrap conditions
    logic hit_last;
    logic pix_last;
    logic acq_last;
    logic frame_last;

    // registered increment fields
    logic                  incr_vld;
    logic                  incr_bank;
    logic [`HIS_PIX_W-1:0] incr_pix;
    logic [`HIS_NB_W-1:0]  incr_bin;

    assign hit_last   = (hit_cnt == `HIS_DATA_NUM - 1);
    assign pix_last   = (pix_cnt == '1);
    assign acq_last   = (acq_cnt == `HIS_ACQ_NUM - 1);
    assign frame_last = hit_last && pix_last && acq_last;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_cnt    <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            fill_bank  <= 1'b0;
            frame_done <= 1'b0;
            incr_vld   <= 1'b0;
            incr_bank  <= 1'b0;
        end else begin
            incr_vld   <= hit.valid;
            // bank follows fill_bank every cycle, so the memory sees the swap
            // even when no hits come after it
            incr_bank  <= fill_bank;
            frame_done <= hit.valid && frame_last;
            if (hit.valid) begin
                if (hit_last) begin
                    hit_cnt <= '0;
                    if (pix_last) begin
                        pix_cnt <= '0;
                        if (acq_last) begin
                            // frame complete, next hit goes to other bank
                            acq_cnt   <= '0;
                            fill_bank <= ~fill_bank;
                        end else begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end else begin
                    hit_cnt <= hit_cnt + 1'b1;
                end
            end
        end
    end

    // hit tagged with the pixel before the counters move on
    always_ff @(posedge clk) begin
        incr_pix <= pix_cnt;
        incr_bin <= hit.bin;
    end

    assign incr = '{
        valid: incr_vld,
        bank:  incr_bank,
        pix:   incr_pix,
        bin:   incr_bin
    };

endmodule

`default_nettype wire

/* hdl/his_pkg.sv */
`default_nettype none

`include "his_macros.svh"

package his_pkg;

    // one photon hit from the front end
    typedef struct packed {
        logic                 valid;
        logic [`HIS_NB_W-1:0] bin;
    } his_hit_t;

    // increment request, sequencer to bin memory
    typedef struct packed {
        logic                  valid;
        // bank being filled
        logic                  bank;
        logic [`HIS_PIX_W-1:0] pix;
        logic [`HIS_NB_W-1:0]  bin;
    } his_incr_t;

    // read-and-clear request, readout to bin memory
    typedef struct packed {
        logic                  en;
        logic [`HIS_PIX_W-1:0] pix;
        logic [`HIS_NB_W-1:0]  bin;
    } his_rd_req_t;

    // histogram view of the word address
    typedef struct packed {
        // 0 here
        logic                  space;
        logic [`HIS_PIX_W-1:0] pix;
        logic [`HIS_NB_W-1:0]  bin;
    } his_adr_hist_t;

    // register view of the word address
    typedef struct packed {
        // 1 here
        logic                   space;
        logic [`HIS_ADR_W-3:0]  rsvd;
        // 0 status, 1 release
        logic                   idx;
    } his_adr_reg_t;

    // same word, decoded by the space bit
    typedef union packed {
        his_adr_hist_t hist;
        his_adr_reg_t  regs;
    } his_adr_u;

    // wishbone classic, master side
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        his_adr_u              adr;
        logic [`HIS_CNT_W-1:0] dat;
    } his_wb_req_t;

    // wishbone classic, slave side
    typedef struct packed {
        logic                  ack;
        logic [`HIS_CNT_W-1:0] dat;
    } his_wb_rsp_t;

endpackage

`default_nettype wire

/* hdl/his_macros.svh */
`ifndef HIS_MACROS_SVH
`define HIS_MACROS_SVH

// bin index width, 16 time bins per pixel
`define HIS_NB_W 4
// pixel index width, 4 pixels share one bank
`define HIS_PIX_W 2
// hits per pixel in one acquisition
`define HIS_DATA_NUM 8
// acquisitions per frame (96 hits per frame)
`define HIS_ACQ_NUM 3
// bin counter width, saturating
`define HIS_CNT_W 16
// wishbone word address: space bit, pixel, bin
`define HIS_ADR_W 7

// status word layout
`define HIS_ST_READY 0
`define HIS_ST_OVERRUN 1
`define HIS_ST_BANK 2
`define HIS_ST_FRAME_LSB 8
`define HIS_ST_FRAME_W 8

// register index of the release command
`define HIS_REG_RELEASE 1'b1

`endif
